//--- design/bilinear_interp.sv
`timescale 1ns/10ps
`default_nettype none

module bilinear_interp #(
	parameter int ADDR_W = pred_pkg::ADDR_W
) (
	input wire logic clk,
	input wire logic rst_i,
	pred_step_if.interp step,
	input wire pred_pkg::win_row_t top_row_i,
	input wire pred_pkg::win_row_t bot_row_i,
	pred_wr_if.src wr
);

	localparam int PW = pred_pkg::PIX_W;
	localparam int BLK = pred_pkg::BLK;
	localparam int FW = pred_pkg::FRAC_W;
	localparam int WT_W = 2*FW + 1; // weight product, up to 64.
	localparam int PROD_W = PW + WT_W;
	localparam int SUM_W = PROD_W + 2;
	localparam int SHIFT = 2*FW;
	localparam logic [FW:0] FULL = 1 << FW;
	localparam logic [SUM_W-1:0] ROUND = 1 << (SHIFT - 1);

	logic [FW:0] wx0;
	logic [FW:0] wx1;
	logic [FW:0] wy0;
	logic [FW:0] wy1;
	logic [WT_W-1:0] w_a;
	logic [WT_W-1:0] w_b;
	logic [WT_W-1:0] w_c;
	logic [WT_W-1:0] w_d;

	logic [PROD_W-1:0] prod_q [BLK][4];
	logic [SUM_W-1:0] sum [BLK];
	logic vld_q;
	logic [pred_pkg::ROW_W-1:0] row_q;
	logic [ADDR_W-1:0] addr_q;

	assign wx1 = {1'b0, step.frac_x};
	assign wx0 = FULL - wx1;
	assign wy1 = {1'b0, step.frac_y};
	assign wy0 = FULL - wy1;

	assign w_a = wx0 * wy0;
	assign w_b = wx1 * wy0;
	assign w_c = wx0 * wy1;
	assign w_d = wx1 * wy1; // weights always add up to 64.

	//##################################################
	// stage one: corner products
	//##################################################
	always_ff @(posedge clk) begin
		for (int c = 0; c < BLK; c++) begin
			prod_q[c][0] <= top_row_i[c*PW +: PW] * w_a;
			prod_q[c][1] <= top_row_i[(c+1)*PW +: PW] * w_b;
			prod_q[c][2] <= bot_row_i[c*PW +: PW] * w_c;
			prod_q[c][3] <= bot_row_i[(c+1)*PW +: PW] * w_d;
		end
		row_q <= step.row;
		addr_q <= step.blk_addr;
	end

	//##################################################
	// stage two: sum, round and scale
	//##################################################
	always_comb begin
		for (int c = 0; c < BLK; c++) begin
			sum[c] = prod_q[c][0] + prod_q[c][1] + prod_q[c][2] + prod_q[c][3] + ROUND;
		end
	end

	always_ff @(posedge clk) begin
		for (int c = 0; c < BLK; c++) begin
			wr.pix[c*PW +: PW] <= sum[c][SHIFT +: PW];
		end
		wr.row <= row_q;
		wr.blk_addr <= addr_q;
	end

	always_ff @(posedge clk) begin
		if (rst_i) begin
			vld_q <= 1'b0;
			wr.wr <= 1'b0;
		end else begin
			vld_q <= step.step_valid;
			wr.wr <= vld_q;
		end
	end

endmodule

`default_nettype wire

//--- design/inter_pred_top.sv
`timescale 1ns/10ps
`default_nettype none

module inter_pred_top #(
	parameter int ADDR_W = pred_pkg::ADDR_W
) (
	input wire logic clk,
	input wire logic rst_i,

	input wire logic ref_row_wr_i,
	input wire logic [2:0] ref_row_idx_i,
	input wire pred_pkg::win_row_t ref_row_i,

	input wire logic start_i,
	input wire logic [ADDR_W-1:0] blk_addr_i,
	input wire logic [pred_pkg::FRAC_W-1:0] frac_x_i,
	input wire logic [pred_pkg::FRAC_W-1:0] frac_y_i,
	output logic busy_o,
	output logic done_o,

	input wire logic [ADDR_W-1:0] rd_addr_i,
	output logic [pred_pkg::BLK*pred_pkg::BLK*pred_pkg::PIX_W-1:0] pred_o
);

	logic run;
	logic drain;
	logic last_step;
	logic drain_done;
	pred_pkg::win_row_t top_row;
	pred_pkg::win_row_t bot_row;

	pred_step_if #(.ADDR_W(ADDR_W)) step_if ();
	pred_wr_if #(.ADDR_W(ADDR_W)) wr_if ();

	//##################################################
	// control
	//##################################################
	pred_fsm #(.ADDR_W(ADDR_W)) u_fsm (
		.clk(clk),
		.rst_i(rst_i),
		.start_i(start_i),
		.frac_x_i(frac_x_i),
		.frac_y_i(frac_y_i),
		.blk_addr_i(blk_addr_i),
		.last_step_i(last_step),
		.drain_done_i(drain_done),
		.run_o(run),
		.drain_o(drain),
		.busy_o(busy_o),
		.done_o(done_o),
		.step(step_if.ctrl)
	);

	pred_step_counter u_counter (
		.clk(clk),
		.rst_i(rst_i),
		.run_i(run),
		.drain_i(drain),
		.last_step_o(last_step),
		.drain_done_o(drain_done),
		.step(step_if.ctrl)
	);

	//##################################################
	// data path
	//##################################################
	ref_window u_window (
		.clk(clk),
		.row_wr_i(ref_row_wr_i),
		.row_idx_i(ref_row_idx_i),
		.row_data_i(ref_row_i),
		.step(step_if.win),
		.top_row_o(top_row),
		.bot_row_o(bot_row)
	);

	bilinear_interp #(.ADDR_W(ADDR_W)) u_interp (
		.clk(clk),
		.rst_i(rst_i),
		.step(step_if.interp),
		.top_row_i(top_row),
		.bot_row_i(bot_row),
		.wr(wr_if.src)
	);

	pred_out_store #(.ADDR_W(ADDR_W)) u_store (
		.clk(clk),
		.wr(wr_if.dst),
		.rd_addr_i(rd_addr_i),
		.pred_o(pred_o)
	);

endmodule

`default_nettype wire

//--- design/pred_fsm.sv
`timescale 1ns/10ps
`default_nettype none

module pred_fsm #(
	parameter int ADDR_W = pred_pkg::ADDR_W
) (
	input wire logic clk,
	input wire logic rst_i,
	input wire logic start_i,
	input wire logic [pred_pkg::FRAC_W-1:0] frac_x_i,
	input wire logic [pred_pkg::FRAC_W-1:0] frac_y_i,
	input wire logic [ADDR_W-1:0] blk_addr_i,
	input wire logic last_step_i,
	input wire logic drain_done_i,
	output logic run_o,
	output logic drain_o,
	output logic busy_o,
	output logic done_o,
	pred_step_if.ctrl step
);

	localparam logic [1:0] S_IDLE = 2'd0;
	localparam logic [1:0] S_RUN = 2'd1;
	localparam logic [1:0] S_DRAIN = 2'd2;

	logic [1:0] state_q;
	logic [pred_pkg::FRAC_W-1:0] frac_x_q;
	logic [pred_pkg::FRAC_W-1:0] frac_y_q;
	logic [ADDR_W-1:0] addr_q;

	always_ff @(posedge clk) begin
		if (rst_i) begin
			state_q <= S_IDLE;
			done_o <= 1'b0;
		end else begin
			done_o <= 1'b0;
			case (state_q)
				S_IDLE: if (start_i) state_q <= S_RUN;
				S_RUN: if (last_step_i) state_q <= S_DRAIN;
				S_DRAIN: if (drain_done_i) begin
					state_q <= S_IDLE;
					done_o <= 1'b1; // last row is in the store now.
				end
				default: state_q <= S_IDLE;
			endcase
		end
	end

	// block parameters are held for the whole block.
	always_ff @(posedge clk) begin
		if (state_q == S_IDLE && start_i) begin
			frac_x_q <= frac_x_i;
			frac_y_q <= frac_y_i;
			addr_q <= blk_addr_i;
		end
	end

	assign run_o = (state_q == S_RUN);
	assign drain_o = (state_q == S_DRAIN);
	assign busy_o = (state_q != S_IDLE);

	assign step.blk_addr = addr_q;
	assign step.frac_x = frac_x_q;
	assign step.frac_y = frac_y_q;

endmodule

`default_nettype wire

//--- design/pred_out_store.sv
`timescale 1ns/10ps
`default_nettype none

module pred_out_store #(
	parameter int ADDR_W = pred_pkg::ADDR_W
) (
	input wire logic clk,
	pred_wr_if.dst wr,
	input wire logic [ADDR_W-1:0] rd_addr_i,
	output logic [pred_pkg::BLK*pred_pkg::BLK*pred_pkg::PIX_W-1:0] pred_o
);

	localparam int PW = pred_pkg::PIX_W;
	localparam int BLK = pred_pkg::BLK;
	localparam int RW = pred_pkg::ROW_W;
	localparam int DEPTH = 1 << ADDR_W;

	//##################################################
	// one pixel RAM per block position
	//##################################################
	for (genvar p = 0; p < BLK*BLK; p++) begin : g_ram
		localparam logic [RW-1:0] ROW = RW'(p / BLK);
		localparam int COL = p % BLK;

		pred_pkg::pixel_t mem [DEPTH];
		pred_pkg::pixel_t rd_q;
		logic wr_en;

		// a row write hits the four RAMs of that row.
		assign wr_en = wr.wr && (wr.row == ROW);

		always_ff @(posedge clk) begin
			if (wr_en) begin
				mem[wr.blk_addr] <= wr.pix[COL*PW +: PW];
			end
		end

		always_ff @(posedge clk) begin
			rd_q <= mem[rd_addr_i]; // whole block, one cycle.
		end

		assign pred_o[p*PW +: PW] = rd_q;
	end

endmodule

`default_nettype wire

//--- design/pred_pkg.sv
`default_nettype none

package pred_pkg;

	//##################################################
	// geometry
	//##################################################
	localparam int PIX_W = 8; // luma sample width.
	localparam int BLK = 4; // predicted block side.
	localparam int WIN = BLK + 1; // reference window side.
	localparam int FRAC_W = 3; // eighth-pel fraction.
	localparam int ROW_W = $clog2(BLK); // row index inside a block.
	localparam int ADDR_W = 5; // default store depth, 32 blocks.

	// stages between a row step and its store write.
	localparam int INTERP_LAT = 2;

	//##################################################
	// pixel types
	//##################################################
	typedef logic [PIX_W-1:0] pixel_t;

	// pixel c of a row sits at bits [c*PIX_W +: PIX_W].
	typedef logic [WIN*PIX_W-1:0] win_row_t;
	typedef logic [BLK*PIX_W-1:0] blk_row_t;

endpackage

`default_nettype wire

//--- design/pred_step_counter.sv
`timescale 1ns/10ps
`default_nettype none

module pred_step_counter (
	input wire logic clk,
	input wire logic rst_i,
	input wire logic run_i,
	input wire logic drain_i,
	output logic last_step_o,
	output logic drain_done_o,
	pred_step_if.ctrl step
);

	localparam int RW = pred_pkg::ROW_W;
	localparam int DRAIN_W = $clog2(pred_pkg::INTERP_LAT + 1);

	logic [RW-1:0] row_q;
	logic [DRAIN_W-1:0] drain_q;

	assign step.step_valid = run_i; // one row per run cycle.
	assign step.row = row_q;

	assign last_step_o = run_i && (row_q == RW'(pred_pkg::BLK - 1));

	// drain lasts INTERP_LAT+1 cycles, counting down to zero.
	assign drain_done_o = drain_i && (drain_q == '0);

	always_ff @(posedge clk) begin
		if (rst_i) begin
			row_q <= '0;
			drain_q <= DRAIN_W'(pred_pkg::INTERP_LAT);
		end else begin
			if (last_step_o) begin
				row_q <= '0;
			end else if (run_i) begin
				row_q <= row_q + 1'b1;
			end

			if (drain_done_o) begin
				drain_q <= DRAIN_W'(pred_pkg::INTERP_LAT); // ready for next block.
			end else if (drain_i) begin
				drain_q <= drain_q - 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

//--- design/pred_step_if.sv
`timescale 1ns/10ps
`default_nettype none

interface pred_step_if #(
	parameter int ADDR_W = pred_pkg::ADDR_W
) ();

	logic step_valid; // one strobe per block row.
	logic [pred_pkg::ROW_W-1:0] row;
	logic [ADDR_W-1:0] blk_addr;
	logic [pred_pkg::FRAC_W-1:0] frac_x;
	logic [pred_pkg::FRAC_W-1:0] frac_y;

	// fsm and step counter each drive their own part.
	modport ctrl (
		output step_valid, row, blk_addr, frac_x, frac_y
	);

	modport win (
		input row
	);

	modport interp (
		input step_valid, row, blk_addr, frac_x, frac_y
	);

endinterface

`default_nettype wire

//--- design/pred_wr_if.sv
`timescale 1ns/10ps
`default_nettype none

interface pred_wr_if #(
	parameter int ADDR_W = pred_pkg::ADDR_W
) ();

	logic wr; // write strobe for one block row.
	logic [pred_pkg::ROW_W-1:0] row;
	logic [ADDR_W-1:0] blk_addr;
	pred_pkg::blk_row_t pix;

	modport src (
		output wr, row, blk_addr, pix
	);

	modport dst (
		input wr, row, blk_addr, pix
	);

endinterface

`default_nettype wire

//--- design/ref_window.sv
`timescale 1ns/10ps
`default_nettype none

module ref_window (
	input wire logic clk,
	input wire logic row_wr_i,
	input wire logic [2:0] row_idx_i,
	input wire pred_pkg::win_row_t row_data_i,
	pred_step_if.win step,
	output pred_pkg::win_row_t top_row_o,
	output pred_pkg::win_row_t bot_row_o
);

	//##################################################
	// window storage
	//##################################################
	pred_pkg::win_row_t rows [pred_pkg::WIN];

	logic [2:0] top_idx;
	logic [2:0] bot_idx;

	// indices past the last window row are dropped.
	always_ff @(posedge clk) begin
		if (row_wr_i && (row_idx_i < 3'(pred_pkg::WIN))) begin
			rows[row_idx_i] <= row_data_i;
		end
	end

	//##################################################
	// two-row read for the current step
	//##################################################
	assign top_idx = {1'b0, step.row};
	assign bot_idx = top_idx + 3'd1;

	// bilinear needs rows r and r+1 in the same cycle.
	assign top_row_o = rows[top_idx];
	assign bot_row_o = rows[bot_idx];

endmodule

`default_nettype wire

//--- inter_pred.f
design/pred_pkg.sv
design/pred_step_if.sv
design/pred_wr_if.sv
design/pred_fsm.sv
design/pred_step_counter.sv
design/ref_window.sv
design/bilinear_interp.sv
design/pred_out_store.sv
design/inter_pred_top.sv
tb/tb_inter_pred.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timing -Wno-fatal --top-module tb_inter_pred \
	-f inter_pred.f -o tb_inter_pred

./obj_dir/tb_inter_pred | tee sim.log

if grep -qx "No errors" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi

//--- tb/tb_inter_pred.sv
`timescale 1ns/10ps
`default_nettype none

module tb_inter_pred;

	localparam int ADDR_W = pred_pkg::ADDR_W;
	localparam int FW = pred_pkg::FRAC_W;
	localparam int DEPTH = 1 << ADDR_W;
	localparam int N_RANDOM = 40;
	localparam int TIMEOUT_CYCLES = 3000; // about 60 blocks of 12 cycles, plus margin.

	logic clk;
	logic rst_i;
	logic ref_row_wr_i;
	logic [2:0] ref_row_idx_i;
	pred_pkg::win_row_t ref_row_i;
	logic start_i;
	logic [ADDR_W-1:0] blk_addr_i;
	logic [FW-1:0] frac_x_i;
	logic [FW-1:0] frac_y_i;
	logic busy_o;
	logic done_o;
	logic [ADDR_W-1:0] rd_addr_i;
	logic [127:0] pred_o;

	logic [31:0] rng;
	logic [7:0] win_m [5][5]; // window as the testbench wrote it.
	logic [127:0] store_m [DEPTH];
	logic written [DEPTH];
	int errors = 0;
	int checks = 0;
	int cycles = 0;

	inter_pred_top #(.ADDR_W(ADDR_W)) dut0 (
		.clk(clk),
		.rst_i(rst_i),
		.ref_row_wr_i(ref_row_wr_i),
		.ref_row_idx_i(ref_row_idx_i),
		.ref_row_i(ref_row_i),
		.start_i(start_i),
		.blk_addr_i(blk_addr_i),
		.frac_x_i(frac_x_i),
		.frac_y_i(frac_y_i),
		.busy_o(busy_o),
		.done_o(done_o),
		.rd_addr_i(rd_addr_i),
		.pred_o(pred_o)
	);

	always #20 clk = ~clk;

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("Errors found");
			$finish;
		end
	end

	//##################################################
	// reference model
	//##################################################
	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] s;
		s = x;
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	function automatic logic [7:0] bilinear_pixel(input int r, input int c, input int fx,
		input int fy);
		int acc;
		acc = (8 - fx) * (8 - fy) * int'(win_m[r][c]) + fx * (8 - fy) * int'(win_m[r][c+1])
			+ (8 - fx) * fy * int'(win_m[r+1][c]) + fx * fy * int'(win_m[r+1][c+1]) + 32;
		return 8'(acc >> 6);
	endfunction

	function automatic logic [127:0] expected_block(input int fx, input int fy);
		logic [127:0] blk;
		for (int p = 0; p < 16; p++) begin
			blk[p*8 +: 8] = bilinear_pixel(p / 4, p % 4, fx, fy);
		end
		return blk;
	endfunction

	//##################################################
	// stimulus and checks
	//##################################################
	task automatic tick();
		@(posedge clk);
		#2; // inputs change just after the edge.
	endtask

	task automatic expect_true(input logic ok, input string what);
		checks++;
		assert (ok) else begin
			errors++;
			$display("FAIL at %0t: %s", $time, what);
		end
	endtask

	task automatic load_random_window();
		logic [39:0] row;
		for (int r = 0; r < 5; r++) begin
			rng = xorshift32(rng);
			row[31:0] = rng;
			rng = xorshift32(rng);
			row[39:32] = rng[7:0];
			for (int c = 0; c < 5; c++) begin
				win_m[r][c] = row[c*8 +: 8];
			end
			ref_row_wr_i = 1'b1;
			ref_row_idx_i = 3'(r);
			ref_row_i = row;
			tick();
		end
		ref_row_wr_i = 1'b0;
	endtask

	task automatic start_block(input logic [ADDR_W-1:0] addr, input int fx, input int fy);
		expect_true(!busy_o, "busy_o was still high when a new block was started");
		start_i = 1'b1;
		blk_addr_i = addr;
		frac_x_i = FW'(fx);
		frac_y_i = FW'(fy);
		tick();
		start_i = 1'b0;
		store_m[addr] = expected_block(fx, fy);
		written[addr] = 1'b1;
	endtask

	task automatic wait_done();
		while (!done_o) begin
			tick(); // the cycle counter ends a hung block.
		end
	endtask

	task automatic compare_stored(input logic [ADDR_W-1:0] addr);
		logic [127:0] exp_blk;
		rd_addr_i = addr;
		tick();
		exp_blk = store_m[addr];
		for (int p = 0; p < 16; p++) begin
			checks++;
			assert (pred_o[p*8 +: 8] == exp_blk[p*8 +: 8]) else begin
				errors++;
				$display("FAIL at %0t: block %0d pixel (%0d,%0d) is %0d, expected %0d",
					$time, addr, p / 4, p % 4, pred_o[p*8 +: 8], exp_blk[p*8 +: 8]);
			end
		end
	endtask

	task automatic compare_all_stored();
		for (int a = 0; a < DEPTH; a++) begin
			if (written[a]) begin
				compare_stored(ADDR_W'(a));
			end
		end
	endtask

	task automatic report_test(input string name, input int err_before);
		if (errors == err_before) begin
			$display("test %s: passed", name);
		end else begin
			$display("test %s: failed with %0d errors", name, errors - err_before);
		end
	endtask

	initial begin
		int err0;
		int dones;
		logic [ADDR_W-1:0] a1;
		logic [ADDR_W-1:0] a2;
		clk = 1'b0;
		rst_i = 1'b1;
		ref_row_wr_i = 1'b0;
		ref_row_idx_i = '0;
		ref_row_i = '0;
		start_i = 1'b0;
		blk_addr_i = '0;
		frac_x_i = '0;
		frac_y_i = '0;
		rd_addr_i = '0;
		rng = 32'he456;
		for (int a = 0; a < DEPTH; a++) begin
			written[a] = 1'b0;
		end
		repeat (4) @(posedge clk);
		#2;
		rst_i = 1'b0;

		err0 = errors;
		repeat (4) begin
			tick();
			expect_true(!busy_o && !done_o, "busy_o or done_o went high while idle");
		end
		report_test("1 idle after reset", err0);

		// full-pel copy is checked against the window itself.
		err0 = errors;
		load_random_window();
		rng = xorshift32(rng);
		a1 = rng[ADDR_W-1:0];
		start_block(a1, 0, 0);
		wait_done();
		for (int p = 0; p < 16; p++) begin
			store_m[a1][p*8 +: 8] = win_m[p / 4][p % 4];
		end
		compare_stored(a1);
		report_test("2 full-pel copy", err0);

		err0 = errors;
		for (int n = 0; n < N_RANDOM; n++) begin
			load_random_window();
			rng = xorshift32(rng);
			start_block(rng[ADDR_W-1:0], int'(rng[10:8]), int'(rng[13:11]));
			wait_done();
		end
		compare_all_stored();
		report_test("3 random fractions", err0);

		err0 = errors;
		load_random_window();
		rng = xorshift32(rng);
		a1 = rng[ADDR_W-1:0];
		start_block(a1, int'(rng[10:8]), int'(rng[13:11]));
		for (int e = 1; e <= 6; e++) begin
			tick();
			expect_true(busy_o && !done_o, "busy_o dropped or done_o came early in a block");
		end
		tick();
		expect_true(done_o && !busy_o, "done_o did not rise 7 edges after start");
		tick();
		expect_true(!done_o, "done_o was longer than one cycle");
		compare_stored(a1);
		report_test("4 start to done timing", err0);

		err0 = errors;
		load_random_window();
		rng = xorshift32(rng);
		a1 = rng[ADDR_W-1:0];
		a2 = a1 + 1'b1;
		start_block(a1, int'(rng[10:8]), int'(rng[13:11]));
		start_i = 1'b1; // second start lands on a busy edge.
		blk_addr_i = a2;
		frac_x_i = ~rng[10:8];
		frac_y_i = ~rng[13:11];
		dones = 0;
		for (int i = 0; i < 16; i++) begin
			tick();
			start_i = 1'b0;
			if (done_o) begin
				dones++;
			end
		end
		expect_true(dones == 1, "a start while busy did not give exactly one done pulse");
		compare_all_stored();
		report_test("5 start ignored while busy", err0);

		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

`default_nettype wire
